//--- rtl/sad_pkg.sv
// shared widths, types and the determinant term table for the attention core; import where needed
package sad_pkg;

    localparam int D_MODEL     = 8;
    localparam int MAT_SIZE    = 64;
    localparam int A_SIZE      = 16;
    localparam int LOAD_CYCLES = 192;
    localparam int DET_TERMS   = 24;

    typedef logic signed [5:0]  a_elem_t;
    typedef logic signed [7:0]  x_elem_t;
    typedef logic        [3:0]  t_rows_t;
    typedef logic signed [18:0] proj_t;
    typedef logic signed [37:0] score_raw_t;
    typedef logic signed [36:0] score_t;
    typedef logic signed [24:0] det_t;
    typedef logic signed [53:0] sv_t;
    typedef logic signed [91:0] out_t;
    typedef logic        [5:0]  mat_idx_t;
    typedef logic        [7:0]  load_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        DET,
        PROJ,
        SCORE,
        OUTPUT
    } phase_t;

    // Leibniz term table, permutations in lexicographic order
    // result bits [2r+1:2r] are the column used in row r, bit 8 set means negative
    function automatic logic [8:0] det_perm(input logic [4:0] term);
        logic [1:0] digit [4];
        logic [3:0] used;
        logic [2:0] rank;
        logic [8:0] res;
        // factorial number system digits of the term number
        digit[0] = 2'(term / 5'd6);
        digit[1] = 2'((term % 5'd6) / 5'd2);
        digit[2] = 2'(term % 5'd2);
        digit[3] = 2'd0;
        used = '0;
        res  = '0;
        for (int r = 0; r < 4; r++) begin
            rank = '0;
            for (int c = 0; c < 4; c++) begin
                if (!used[c]) begin
                    if (rank == {1'b0, digit[r]}) begin
                        res[2*r +: 2] = 2'(c);
                        used[c] = 1'b1;
                    end
                    rank = rank + 3'd1;
                end
            end
        end
        // inversion count is the digit sum, so its parity gives the sign
        res[8] = digit[0][0] ^ digit[1][0] ^ digit[2][0];
        return res;
    endfunction

endpackage

//--- rtl/sad_ctrl.sv
// phase FSM of the attention core, sequences load, determinant, projection, score and output
`timescale 1ns/1ps

module sad_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  sad_pkg::t_rows_t   T,
    output logic               load_en,
    output logic               x_we,
    output logic               frame_start,
    output logic               det_en,
    output logic               proj_en,
    output logic               score_en,
    output logic               out_en,
    output sad_pkg::load_idx_t load_idx,
    output logic [4:0]         det_idx,
    output logic [1:0]         proj_sel,
    output sad_pkg::mat_idx_t  proj_idx,
    output sad_pkg::mat_idx_t  score_idx,
    output sad_pkg::mat_idx_t  out_idx
);
    import sad_pkg::*;

    phase_t     phase;
    phase_t     phase_nxt;
    t_rows_t    t_reg;
    t_rows_t    t_cur;
    load_idx_t  load_cnt;
    logic [4:0] det_cnt;
    logic [7:0] proj_cnt;
    logic [6:0] score_cnt;
    logic [6:0] out_cnt;
    logic [6:0] rows8;
    logic       load_done;
    logic       det_done;
    logic       proj_done;
    logic       score_done;
    logic       out_done;

    // T is live on the first load cycle, held afterwards
    assign t_cur = frame_start ? T : t_reg;
    assign rows8 = {t_reg, 3'b000};

    // each count stops one step past its last item, leaving a gap cycle
    assign load_done  = (load_cnt == load_idx_t'(LOAD_CYCLES));
    assign det_done   = (det_cnt == 5'(DET_TERMS));
    assign proj_done  = (proj_cnt == 8'(3 * MAT_SIZE));
    assign score_done = (score_cnt == 7'(MAT_SIZE));
    // two more cycles so the output pipeline drains before IDLE
    assign out_done   = (out_cnt == rows8 + 7'd1);

    assign frame_start = (phase == IDLE) && in_valid;
    assign load_en     = frame_start || (phase == LOAD && !load_done);
    assign x_we        = load_en && (load_cnt < {1'b0, t_cur, 3'b000});
    assign det_en      = (phase == DET) && !det_done;
    assign proj_en     = (phase == PROJ) && !proj_done;
    assign score_en    = (phase == SCORE) && !score_done;
    assign out_en      = (phase == OUTPUT) && (out_cnt < rows8);

    assign load_idx  = load_cnt;
    assign det_idx   = det_cnt;
    assign proj_sel  = proj_cnt[7:6];
    assign proj_idx  = proj_cnt[5:0];
    assign score_idx = score_cnt[5:0];
    assign out_idx   = out_cnt[5:0];

    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE:    if (in_valid)   phase_nxt = LOAD;
            LOAD:    if (load_done)  phase_nxt = DET;
            DET:     if (det_done)   phase_nxt = PROJ;
            PROJ:    if (proj_done)  phase_nxt = SCORE;
            SCORE:   if (score_done) phase_nxt = OUTPUT;
            OUTPUT:  if (out_done)   phase_nxt = IDLE;
            default: phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= IDLE;
            t_reg     <= '0;
            load_cnt  <= '0;
            det_cnt   <= '0;
            proj_cnt  <= '0;
            score_cnt <= '0;
            out_cnt   <= '0;
        end else begin
            phase <= phase_nxt;
            if (frame_start)
                t_reg <= T;
            // counters fall back to zero outside their own phase
            load_cnt  <= load_en ? load_cnt + 8'd1 : '0;
            det_cnt   <= det_en ? det_cnt + 5'd1 : '0;
            proj_cnt  <= proj_en ? proj_cnt + 8'd1 : '0;
            score_cnt <= score_en ? score_cnt + 7'd1 : '0;
            out_cnt   <= (phase == OUTPUT && !out_done) ? out_cnt + 7'd1 : '0;
        end
    end

    // only 1, 4 and 8 token rows are supported
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> (T == 4'd1 || T == 4'd4 || T == 4'd8))
        else $error("unsupported token count %0d", T);

endmodule

//--- rtl/input_buffer.sv
// frame input storage, routes A, token rows and the three weight streams into row-major matrices
`timescale 1ns/1ps

module input_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_en,
    input  logic               x_we,
    input  logic               frame_start,
    input  sad_pkg::load_idx_t load_idx,
    input  sad_pkg::a_elem_t   in_data1,
    input  sad_pkg::x_elem_t   in_data2,
    input  sad_pkg::x_elem_t   w_Q,
    input  sad_pkg::x_elem_t   w_K,
    input  sad_pkg::x_elem_t   w_V,
    output sad_pkg::a_elem_t   a_mat  [sad_pkg::A_SIZE],
    output sad_pkg::x_elem_t   x_mat  [sad_pkg::MAT_SIZE],
    output sad_pkg::x_elem_t   wq_mat [sad_pkg::MAT_SIZE],
    output sad_pkg::x_elem_t   wk_mat [sad_pkg::MAT_SIZE],
    output sad_pkg::x_elem_t   wv_mat [sad_pkg::MAT_SIZE]
);
    import sad_pkg::*;

    // token rows past T must read as zero, so X starts each frame cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_mat <= '{default: '0};
        end else begin
            if (frame_start)
                x_mat <= '{default: '0};
            if (x_we)
                x_mat[load_idx[5:0]] <= in_data2;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && load_idx < load_idx_t'(A_SIZE))
            a_mat[load_idx[3:0]] <= in_data1;
        // weights arrive back to back, the top two index bits pick the bank
        if (load_en) begin
            case (load_idx[7:6])
                2'd0:    wq_mat[load_idx[5:0]] <= w_Q;
                2'd1:    wk_mat[load_idx[5:0]] <= w_K;
                2'd2:    wv_mat[load_idx[5:0]] <= w_V;
                default: ;
            endcase
        end
    end

    // the controller must never run the load window past its end
    assert property (@(posedge clk) disable iff (!rst_n)
        load_en |-> load_idx < load_idx_t'(LOAD_CYCLES))
        else $error("load index %0d beyond load window", load_idx);

endmodule

//--- rtl/det_unit.sv
// 4x4 determinant of A, one signed Leibniz term accumulated per cycle
`timescale 1ns/1ps

module det_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             det_en,
    input  logic [4:0]       det_idx,
    input  sad_pkg::a_elem_t a_mat [sad_pkg::A_SIZE],
    output sad_pkg::det_t    det
);
    import sad_pkg::*;

    logic [8:0] perm;
    det_t       mag;
    det_t       term;

    assign perm = det_perm(det_idx);

    // one entry from every row, the column chosen by the permutation
    assign mag = a_mat[{2'd0, perm[1:0]}] * a_mat[{2'd1, perm[3:2]}]
               * a_mat[{2'd2, perm[5:4]}] * a_mat[{2'd3, perm[7:6]}];
    assign term = perm[8] ? -mag : mag;

    // first term of a frame restarts the sum
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            det <= '0;
        else if (det_en)
            det <= (det_idx == 5'd0) ? term : det + term;
    end

endmodule

//--- rtl/proj_unit.sv
// Q, K and V projections, one eight-term dot product of X row by weight column per cycle
`timescale 1ns/1ps

module proj_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              proj_en,
    input  logic [1:0]        proj_sel,
    input  sad_pkg::mat_idx_t proj_idx,
    input  sad_pkg::x_elem_t  x_mat  [sad_pkg::MAT_SIZE],
    input  sad_pkg::x_elem_t  wq_mat [sad_pkg::MAT_SIZE],
    input  sad_pkg::x_elem_t  wk_mat [sad_pkg::MAT_SIZE],
    input  sad_pkg::x_elem_t  wv_mat [sad_pkg::MAT_SIZE],
    output sad_pkg::proj_t    q_mat  [sad_pkg::MAT_SIZE],
    output sad_pkg::proj_t    k_mat  [sad_pkg::MAT_SIZE],
    output sad_pkg::proj_t    v_mat  [sad_pkg::MAT_SIZE]
);
    import sad_pkg::*;

    logic [2:0] row;
    logic [2:0] col;
    x_elem_t    w_col [D_MODEL];
    proj_t      dot;
    logic       wr_en;
    logic [1:0] wr_sel;
    mat_idx_t   wr_idx;
    proj_t      wr_dot;

    assign row = proj_idx[5:3];
    assign col = proj_idx[2:0];

    // column col of the selected weight matrix
    always_comb begin
        for (int k = 0; k < D_MODEL; k++) begin
            case (proj_sel)
                2'd0:    w_col[k] = wq_mat[{3'(k), col}];
                2'd1:    w_col[k] = wk_mat[{3'(k), col}];
                default: w_col[k] = wv_mat[{3'(k), col}];
            endcase
        end
    end

    always_comb begin
        dot = '0;
        for (int k = 0; k < D_MODEL; k++)
            dot = dot + x_mat[{row, 3'(k)}] * w_col[k];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_en <= 1'b0;
        else
            wr_en <= proj_en;
    end

    // result lands one cycle after its dot product
    always_ff @(posedge clk) begin
        if (proj_en) begin
            wr_sel <= proj_sel;
            wr_idx <= proj_idx;
            wr_dot <= dot;
        end
        if (wr_en) begin
            case (wr_sel)
                2'd0:    q_mat[wr_idx] <= wr_dot;
                2'd1:    k_mat[wr_idx] <= wr_dot;
                default: v_mat[wr_idx] <= wr_dot;
            endcase
        end
    end

endmodule

//--- rtl/score_unit.sv
// attention scores S = relu(Q K^T) / 3, one entry per cycle
`timescale 1ns/1ps

module score_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              score_en,
    input  sad_pkg::mat_idx_t score_idx,
    input  sad_pkg::proj_t    q_mat [sad_pkg::MAT_SIZE],
    input  sad_pkg::proj_t    k_mat [sad_pkg::MAT_SIZE],
    output sad_pkg::score_t   s_mat [sad_pkg::MAT_SIZE]
);
    import sad_pkg::*;

    logic [2:0]  qi;
    logic [2:0]  kj;
    score_raw_t  raw;
    logic        st_en;
    mat_idx_t    st_idx;
    score_raw_t  st_raw;
    logic [36:0] pos;

    assign qi = score_idx[5:3];
    assign kj = score_idx[2:0];

    // row qi of Q against row kj of K
    always_comb begin
        raw = '0;
        for (int k = 0; k < D_MODEL; k++)
            raw = raw + q_mat[{qi, 3'(k)}] * k_mat[{kj, 3'(k)}];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            st_en <= 1'b0;
        else
            st_en <= score_en;
    end

    // relu, then the magnitude is safe to treat as unsigned
    assign pos = st_raw[37] ? '0 : st_raw[36:0];

    always_ff @(posedge clk) begin
        if (score_en) begin
            st_idx <= score_idx;
            st_raw <= raw;
        end
        if (st_en)
            s_mat[st_idx] <= score_t'(pos / 37'd3);
    end

endmodule

//--- rtl/out_unit.sv
// output stage, S·V sum per element scaled by det(A), two cycle pipeline to out_data
`timescale 1ns/1ps

module out_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              out_en,
    input  sad_pkg::mat_idx_t out_idx,
    input  sad_pkg::score_t   s_mat [sad_pkg::MAT_SIZE],
    input  sad_pkg::proj_t    v_mat [sad_pkg::MAT_SIZE],
    input  sad_pkg::det_t     det,
    output logic              out_valid,
    output sad_pkg::out_t     out_data
);
    import sad_pkg::*;

    logic [2:0] row;
    logic [2:0] col;
    sv_t        sv;
    sv_t        sv_reg;
    logic       sv_valid;

    assign row = out_idx[5:3];
    assign col = out_idx[2:0];

    // stage one, row of S times column of V
    always_comb begin
        sv = '0;
        for (int j = 0; j < D_MODEL; j++)
            sv = sv + s_mat[{row, 3'(j)}] * v_mat[{3'(j), col}];
    end

    always_ff @(posedge clk) begin
        if (out_en)
            sv_reg <= sv;
    end

    // stage two, scale by the determinant, data held at zero between beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sv_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            sv_valid  <= out_en;
            out_valid <= sv_valid;
            if (sv_valid)
                out_data <= det * sv_reg;
            else
                out_data <= '0;
        end
    end

endmodule

//--- rtl/sad_top.sv
// attention core top level, connects the phase controller to the datapath units
`timescale 1ns/1ps

module sad_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  sad_pkg::a_elem_t in_data1,
    input  sad_pkg::t_rows_t T,
    input  sad_pkg::x_elem_t in_data2,
    input  sad_pkg::x_elem_t w_Q,
    input  sad_pkg::x_elem_t w_K,
    input  sad_pkg::x_elem_t w_V,
    output logic             out_valid,
    output sad_pkg::out_t    out_data
);
    import sad_pkg::*;

    //##########################################################################
    // controller outputs
    //##########################################################################
    logic       load_en;
    logic       x_we;
    logic       frame_start;
    logic       det_en;
    logic       proj_en;
    logic       score_en;
    logic       out_en;
    load_idx_t  load_idx;
    logic [4:0] det_idx;
    logic [1:0] proj_sel;
    mat_idx_t   proj_idx;
    mat_idx_t   score_idx;
    mat_idx_t   out_idx;

    //##########################################################################
    // stored matrices between the units
    //##########################################################################
    a_elem_t a_mat  [A_SIZE];
    x_elem_t x_mat  [MAT_SIZE];
    x_elem_t wq_mat [MAT_SIZE];
    x_elem_t wk_mat [MAT_SIZE];
    x_elem_t wv_mat [MAT_SIZE];
    proj_t   q_mat  [MAT_SIZE];
    proj_t   k_mat  [MAT_SIZE];
    proj_t   v_mat  [MAT_SIZE];
    score_t  s_mat  [MAT_SIZE];
    det_t    det;

    // port names match the wires above
    sad_ctrl     u_ctrl  (.*);
    input_buffer u_inbuf (.*);
    det_unit     u_det   (.*);
    proj_unit    u_proj  (.*);
    score_unit   u_score (.*);
    out_unit     u_out   (.*);

endmodule

//--- tb/tb_sad.sv
// directed testbench for the attention core, loads frames and checks every output beat against a model
`timescale 1ns/1ps

module tb_sad;
    import sad_pkg::*;

    localparam logic [31:0] SEED         = 32'h8532_304a;
    // seven frames of at most about 650 cycles, plus reset and the idle check
    localparam int          FRAME_CYCLES = 650;
    localparam int          NUM_FRAMES   = 7;
    localparam int          MAX_CYCLES   = NUM_FRAMES * FRAME_CYCLES + 100;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    a_elem_t in_data1;
    t_rows_t T;
    x_elem_t in_data2;
    x_elem_t w_Q;
    x_elem_t w_K;
    x_elem_t w_V;
    logic    out_valid;
    out_t    out_data;

    // frame contents, all row-major
    int a_v  [A_SIZE];
    int x_v  [MAT_SIZE];
    int wq_v [MAT_SIZE];
    int wk_v [MAT_SIZE];
    int wv_v [MAT_SIZE];

    // reference model state
    longint q_m  [MAT_SIZE];
    longint k_m  [MAT_SIZE];
    longint v_m  [MAT_SIZE];
    longint s_m  [MAT_SIZE];
    longint sv_m [MAT_SIZE];
    longint det_val;
    out_t   exp_out [MAT_SIZE];
    int     cycles = 0;

    sad_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
            fail_run($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input out_t exp, input out_t got);
        assert (got == exp)
            else fail_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, got));
    endtask

    //##########################################################################
    // reference model
    //##########################################################################

    // minor of A from rows 1..3, column skip removed
    function automatic longint minor3(input int skip);
        int     cols [3];
        int     n;
        longint m [3][3];
        n = 0;
        for (int c = 0; c < 4; c++) begin
            if (c != skip) begin
                cols[n] = c;
                n++;
            end
        end
        for (int r = 0; r < 3; r++)
            for (int k = 0; k < 3; k++)
                m[r][k] = longint'(a_v[(r + 1) * 4 + cols[k]]);
        return m[0][0] * (m[1][1] * m[2][2] - m[1][2] * m[2][1])
             - m[0][1] * (m[1][0] * m[2][2] - m[1][2] * m[2][0])
             + m[0][2] * (m[1][0] * m[2][1] - m[1][1] * m[2][0]);
    endfunction

    // cofactor expansion along row 0
    function automatic longint det4();
        longint d;
        d = 0;
        for (int c = 0; c < 4; c++) begin
            if (c % 2 == 0)
                d = d + longint'(a_v[c]) * minor3(c);
            else
                d = d - longint'(a_v[c]) * minor3(c);
        end
        return d;
    endfunction

    task automatic build_model(input int t);
        longint xv;
        longint acc;
        out_t   wide;
        det_val = det4();
        for (int i = 0; i < D_MODEL; i++) begin
            for (int c = 0; c < D_MODEL; c++) begin
                q_m[i * 8 + c] = 0;
                k_m[i * 8 + c] = 0;
                v_m[i * 8 + c] = 0;
                for (int k = 0; k < D_MODEL; k++) begin
                    // token rows past T were never loaded
                    xv = (i < t) ? longint'(x_v[i * 8 + k]) : longint'(0);
                    q_m[i * 8 + c] += xv * longint'(wq_v[k * 8 + c]);
                    k_m[i * 8 + c] += xv * longint'(wk_v[k * 8 + c]);
                    v_m[i * 8 + c] += xv * longint'(wv_v[k * 8 + c]);
                end
            end
        end
        for (int i = 0; i < D_MODEL; i++) begin
            for (int j = 0; j < D_MODEL; j++) begin
                acc = 0;
                for (int k = 0; k < D_MODEL; k++)
                    acc += q_m[i * 8 + k] * k_m[j * 8 + k];
                s_m[i * 8 + j] = (acc > 0) ? acc / 3 : longint'(0);
            end
        end
        for (int i = 0; i < D_MODEL; i++) begin
            for (int c = 0; c < D_MODEL; c++) begin
                acc = 0;
                for (int j = 0; j < D_MODEL; j++)
                    acc += s_m[i * 8 + j] * v_m[j * 8 + c];
                sv_m[i * 8 + c] = acc;
                wide = out_t'(det_val);
                exp_out[i * 8 + c] = wide * out_t'(acc);
            end
        end
    endtask

    //##########################################################################
    // stimulus and response collection
    //##########################################################################
    task automatic clear_inputs();
        in_valid = 1'b0;
        in_data1 = '0;
        T        = '0;
        in_data2 = '0;
        w_Q      = '0;
        w_K      = '0;
        w_V      = '0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < A_SIZE; i++)
            a_v[i] = int'($urandom_range(63)) - 32;
        for (int i = 0; i < MAT_SIZE; i++) begin
            x_v[i]  = int'($urandom_range(255)) - 128;
            wq_v[i] = int'($urandom_range(255)) - 128;
            wk_v[i] = int'($urandom_range(255)) - 128;
            wv_v[i] = int'($urandom_range(255)) - 128;
        end
    endtask

    // outside its slot a stream carries junk that the DUT must ignore
    task automatic drive_frame(input int t);
        for (int n = 0; n < LOAD_CYCLES; n++) begin
            @(posedge clk);
            #2;
            in_valid = 1'b1;
            T        = (n == 0) ? t_rows_t'(t) : t_rows_t'($urandom);
            in_data1 = (n < A_SIZE) ? a_elem_t'(a_v[n]) : a_elem_t'($urandom);
            in_data2 = (n < MAT_SIZE) ? x_elem_t'(x_v[n]) : x_elem_t'($urandom);
            w_Q      = (n < 64) ? x_elem_t'(wq_v[n]) : x_elem_t'($urandom);
            w_K      = (n >= 64 && n < 128) ? x_elem_t'(wk_v[n - 64]) : x_elem_t'($urandom);
            w_V      = (n >= 128) ? x_elem_t'(wv_v[n - 128]) : x_elem_t'($urandom);
        end
        @(posedge clk);
        #2;
        clear_inputs();
    endtask

    task automatic collect_output(input string name, input int t);
        int beats;
        beats = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_value({name, " idle data"}, '0, out_data);
            @(negedge clk);
        end
        // burst must be one unbroken run of 8T beats
        while (out_valid) begin
            assert (beats < 8 * t)
                else fail_run($sformatf("%s: out_valid stayed high past %0d beats", name, 8 * t));
            check_value($sformatf("%s beat %0d", name, beats), exp_out[beats], out_data);
            beats++;
            @(negedge clk);
        end
        check_value({name, " data after burst"}, '0, out_data);
        assert (beats == 8 * t)
            else fail_run($sformatf("[FAIL] %s burst length expected %0d actual %0d",
                                    name, 8 * t, beats));
    endtask

    task automatic run_frame(input string name, input int t);
        drive_frame(t);
        collect_output(name, t);
    endtask

    //##########################################################################
    // tests
    //##########################################################################
    task automatic test_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            assert (!out_valid) else fail_run("out_valid went high with no frame loaded");
            check_value("idle after reset", '0, out_data);
        end
    endtask

    task automatic test_t1_random();
        fill_random();
        build_model(1);
        run_frame("t1 random", 1);
    endtask

    task automatic test_t4_random();
        fill_random();
        build_model(4);
        run_frame("t4 random", 4);
    endtask

    // full-scale magnitudes, alternating token signs so half the scores clamp
    task automatic test_t8_extreme();
        for (int r = 0; r < 4; r++)
            for (int c = 0; c < 4; c++)
                a_v[r * 4 + c] = (r == c) ? -32 : 31;
        for (int i = 0; i < D_MODEL; i++) begin
            for (int k = 0; k < D_MODEL; k++) begin
                x_v[i * 8 + k]  = (i % 2 == 1) ? 127 : -128;
                wq_v[i * 8 + k] = -128;
                wk_v[i * 8 + k] = ((i + k) % 2 == 1) ? 127 : -128;
                wv_v[i * 8 + k] = -128;
            end
        end
        build_model(8);
        run_frame("t8 extreme", 8);
    endtask

    task automatic test_det_cases();
        fill_random();
        // row 2 repeats row 0
        for (int c = 0; c < 4; c++)
            a_v[8 + c] = a_v[c];
        for (int i = 0; i < MAT_SIZE; i++)
            exp_out[i] = '0;
        run_frame("singular A", 4);
        fill_random();
        for (int i = 0; i < A_SIZE; i++)
            a_v[i] = (i % 5 == 0) ? 1 : 0;
        build_model(4);
        for (int i = 0; i < MAT_SIZE; i++)
            exp_out[i] = out_t'(sv_m[i]);
        run_frame("identity A", 4);
    endtask

    task automatic test_no_leak();
        fill_random();
        build_model(8);
        run_frame("t8 before t1", 8);
        fill_random();
        build_model(1);
        run_frame("t1 after t8", 1);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        clear_inputs();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_idle_after_reset();
        test_t1_random();
        test_t4_random();
        test_t8_extreme();
        test_det_cases();
        test_no_leak();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- filelist.f
rtl/sad_pkg.sv
rtl/sad_ctrl.sv
rtl/input_buffer.sv
rtl/det_unit.sv
rtl/proj_unit.sv
rtl/score_unit.sv
rtl/out_unit.sv
rtl/sad_top.sv
tb/tb_sad.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_sad -f filelist.f
if ./obj_dir/Vtb_sad | tee /dev/stderr | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
